//--- logic/vid_defines.svh
`ifndef VID_DEFINES_SVH
`define VID_DEFINES_SVH

// Pixel component width
`define VID_PIX_W 8

// Derived widths for the gray datapath
`define VID_OFF_W  (`VID_PIX_W + 1)
`define VID_BRT_W  (`VID_PIX_W + 2)
`define VID_PROD_W (`VID_PIX_W * 2)

// Luma weights, scaled so that they sum to 256
`define VID_W_R 77
`define VID_W_G 150
`define VID_W_B 29

// Configuration after reset
`define VID_BRIGHT_DEFAULT 0
`define VID_THRESH_DEFAULT 128

`endif

//--- logic/vid_pkg.sv
`include "vid_defines.svh"

package vid_pkg;

    // RGB pixel with its sync and data-enable
    typedef struct packed {
        logic                  vsync;
        logic                  hsync;
        logic                  de;
        logic [`VID_PIX_W-1:0] r;
        logic [`VID_PIX_W-1:0] g;
        logic [`VID_PIX_W-1:0] b;
    } vid_rgb_t;

    // Single-component pixel
    typedef struct packed {
        logic                  vsync;
        logic                  hsync;
        logic                  de;
        logic [`VID_PIX_W-1:0] y;
    } vid_mono_t;

    //////////////////////////////
    // Configuration word views
    //////////////////////////////

    // Address 0
    typedef struct packed {
        logic [6:0]                  pad;
        logic signed [`VID_OFF_W-1:0] offset;
    } vid_bright_word_t;

    // Address 1
    typedef struct packed {
        logic [6:0]            pad;
        logic                  en;
        logic [`VID_PIX_W-1:0] thresh;
    } vid_thresh_word_t;

    typedef union packed {
        vid_bright_word_t bright;
        vid_thresh_word_t thresh;
    } vid_cfg_word_u;

    // Live settings seen by the pixel stages
    typedef struct packed {
        logic signed [`VID_OFF_W-1:0] offset;
        logic [`VID_PIX_W-1:0]        thresh;
        logic                         bin_en;
    } vid_cfg_t;

endpackage

//--- logic/vid_cfg_regs.sv
`timescale 1ns/1ps
`include "vid_defines.svh"

module vid_cfg_regs (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_cfg_req,
    input  logic                  i_cfg_addr,
    input  vid_pkg::vid_cfg_word_u i_cfg_data,
    output logic                  o_cfg_ack,
    output vid_pkg::vid_cfg_t      o_cfg
);

    logic wr_phase;
    logic rel_phase;

    // Rising phase: new request while ack is still low
    assign wr_phase  = i_cfg_req && !o_cfg_ack;
    // Falling phase: master has released req
    assign rel_phase = !i_cfg_req && o_cfg_ack;

    //////////////////////////////
    // Handshake
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_cfg_ack <= 1'b0;
        end else if (wr_phase) begin
            o_cfg_ack <= 1'b1;
        end else if (rel_phase) begin
            o_cfg_ack <= 1'b0;
        end
    end

    //////////////////////////////
    // Registers
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_cfg.offset <= `VID_BRIGHT_DEFAULT;
            o_cfg.thresh <= `VID_THRESH_DEFAULT;
            o_cfg.bin_en <= 1'b0;
        end else if (wr_phase) begin
            // Same word, two layouts
            if (i_cfg_addr) begin
                o_cfg.thresh <= i_cfg_data.thresh.thresh;
                o_cfg.bin_en <= i_cfg_data.thresh.en;
            end else begin
                o_cfg.offset <= i_cfg_data.bright.offset;
            end
        end
    end

endmodule

//--- logic/vid_gray_conv.sv
`timescale 1ns/1ps
`include "vid_defines.svh"

module vid_gray_conv (
    input  logic                         clk,
    input  logic                         rstn,
    input  vid_pkg::vid_rgb_t            i_pix,
    input  logic signed [`VID_OFF_W-1:0] i_offset,
    output vid_pkg::vid_mono_t           o_pix
);

    logic [`VID_PROD_W-1:0]       r_prod;
    logic [`VID_PROD_W-1:0]       g_prod;
    logic [`VID_PROD_W-1:0]       b_prod;
    logic [`VID_PROD_W-1:0]       prod_sum;
    logic [`VID_PIX_W-1:0]        gray_sum;
    logic signed [`VID_BRT_W-1:0] gray_bright;
    logic [2:0]                   vs_d;
    logic [2:0]                   hs_d;
    logic [2:0]                   de_d;

    // Constant multiply as a sum of shifted copies
    function automatic logic [`VID_PROD_W-1:0] shift_add(
        input logic [`VID_PIX_W-1:0] x,
        input logic [`VID_PIX_W-1:0] w
    );
        logic [`VID_PROD_W-1:0] acc;
        acc = '0;
        for (int i = 0; i < `VID_PIX_W; i++) begin
            if (w[i]) begin
                acc = acc + ({{`VID_PIX_W{1'b0}}, x} << i);
            end
        end
        return acc;
    endfunction

    // Weights sum to 256, so this never overflows
    assign prod_sum = r_prod + g_prod + b_prod;

    //////////////////////////////
    // Datapath
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_prod      <= '0;
            g_prod      <= '0;
            b_prod      <= '0;
            gray_sum    <= '0;
            gray_bright <= '0;
            o_pix.y     <= '0;
        end else begin
            // Stage 1
            r_prod <= shift_add(i_pix.r, `VID_W_R);
            g_prod <= shift_add(i_pix.g, `VID_W_G);
            b_prod <= shift_add(i_pix.b, `VID_W_B);

            // Stage 2, divide by 256
            gray_sum <= prod_sum[`VID_PROD_W-1:`VID_PROD_W-`VID_PIX_W];

            // Stage 3, blanking keeps the last active value
            if (de_d[1]) begin
                gray_bright <= $signed({2'b00, gray_sum}) + i_offset;
            end

            // Stage 4
            if (gray_bright[`VID_BRT_W-1]) begin
                o_pix.y <= '0;
            end else if (gray_bright[`VID_BRT_W-2]) begin
                o_pix.y <= '1;
            end else begin
                o_pix.y <= gray_bright[`VID_PIX_W-1:0];
            end
        end
    end

    // Syncs follow the data through the same four registers
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vs_d        <= '0;
            hs_d        <= '0;
            de_d        <= '0;
            o_pix.vsync <= 1'b0;
            o_pix.hsync <= 1'b0;
            o_pix.de    <= 1'b0;
        end else begin
            vs_d        <= {vs_d[1:0], i_pix.vsync};
            hs_d        <= {hs_d[1:0], i_pix.hsync};
            de_d        <= {de_d[1:0], i_pix.de};
            o_pix.vsync <= vs_d[2];
            o_pix.hsync <= hs_d[2];
            o_pix.de    <= de_d[2];
        end
    end

endmodule

//--- logic/vid_binarize.sv
`timescale 1ns/1ps
`include "vid_defines.svh"

module vid_binarize (
    input  logic                  clk,
    input  logic                  rstn,
    input  vid_pkg::vid_mono_t    i_pix,
    input  logic [`VID_PIX_W-1:0] i_thresh,
    input  logic                  i_bin_en,
    output vid_pkg::vid_mono_t    o_pix
);

    logic                  above;
    logic [`VID_PIX_W-1:0] y_next;

    assign above = (i_pix.y >= i_thresh);

    // Black or white when enabled, else plain gray
    always_comb begin
        if (i_bin_en) begin
            y_next = above ? {`VID_PIX_W{1'b1}} : {`VID_PIX_W{1'b0}};
        end else begin
            y_next = i_pix.y;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_pix.vsync <= 1'b0;
            o_pix.hsync <= 1'b0;
            o_pix.de    <= 1'b0;
            o_pix.y     <= '0;
        end else begin
            o_pix.vsync <= i_pix.vsync;
            o_pix.hsync <= i_pix.hsync;
            o_pix.de    <= i_pix.de;
            o_pix.y     <= y_next;
        end
    end

endmodule

//--- logic/vid_proc_top.sv
`timescale 1ns/1ps

module vid_proc_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  vid_pkg::vid_rgb_t      i_pix,
    input  logic                   i_cfg_req,
    input  logic                   i_cfg_addr,
    input  vid_pkg::vid_cfg_word_u i_cfg_data,
    output logic                   o_cfg_ack,
    output vid_pkg::vid_mono_t     o_pix
);

    import vid_pkg::*;

    vid_cfg_t  cfg;
    vid_mono_t gray;

    //////////////////////////////
    // Configuration
    //////////////////////////////

    vid_cfg_regs vid_cfg_regs_i (
        .clk        (clk),
        .rstn       (rstn),
        .i_cfg_req  (i_cfg_req),
        .i_cfg_addr (i_cfg_addr),
        .i_cfg_data (i_cfg_data),
        .o_cfg_ack  (o_cfg_ack),
        .o_cfg      (cfg)
    );

    //////////////////////////////
    // Pixel pipeline
    //////////////////////////////

    // Four cycles
    vid_gray_conv vid_gray_conv_i (
        .clk      (clk),
        .rstn     (rstn),
        .i_pix    (i_pix),
        .i_offset (cfg.offset),
        .o_pix    (gray)
    );

    // One cycle
    vid_binarize vid_binarize_i (
        .clk      (clk),
        .rstn     (rstn),
        .i_pix    (gray),
        .i_thresh (cfg.thresh),
        .i_bin_en (cfg.bin_en),
        .o_pix    (o_pix)
    );

endmodule

//--- verif/vid_clk_gen.sv
`timescale 1ns/1ps

module vid_clk_gen (
    output logic o_clk,
    output logic o_rstn
);

    // 10 ns period
    initial begin
        o_clk = 1'b0;
        forever begin
            #5 o_clk = ~o_clk;
        end
    end

    // Reset low across four rising edges, released on a falling edge
    initial begin
        o_rstn = 1'b0;
        repeat (4) @(posedge o_clk);
        @(negedge o_clk);
        o_rstn = 1'b1;
    end

endmodule

//--- verif/vid_proc_sva.sv
`timescale 1ns/1ps

module vid_proc_sva (
    input logic               clk,
    input logic               rstn,
    input logic               i_cfg_req,
    input logic               o_cfg_ack,
    input vid_pkg::vid_rgb_t  i_pix,
    input vid_pkg::vid_mono_t o_pix
);

    int sva_errs = 0;

    // Ack cleared by reset
    ack_in_reset: assert property (@(posedge clk) !rstn |-> !o_cfg_ack)
        else begin
            $error("o_cfg_ack high while rstn is low");
            sva_errs++;
        end

    // Ack only answers a request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        $rose(o_cfg_ack) |-> $past(i_cfg_req))
        else begin
            $error("o_cfg_ack rose without i_cfg_req");
            sva_errs++;
        end

    ack_held: assert property (@(posedge clk) disable iff (!rstn)
        o_cfg_ack && i_cfg_req |=> o_cfg_ack)
        else begin
            $error("o_cfg_ack dropped while i_cfg_req still high");
            sva_errs++;
        end

    // Five registers from input to output
    de_latency: assert property (@(posedge clk) disable iff (!rstn)
        o_pix.de == $past(i_pix.de, 5))
        else begin
            $error("o_pix.de does not follow i_pix.de by 5 cycles");
            sva_errs++;
        end

endmodule

bind vid_proc_top vid_proc_sva vid_proc_sva_i (
    .clk       (clk),
    .rstn      (rstn),
    .i_cfg_req (i_cfg_req),
    .o_cfg_ack (o_cfg_ack),
    .i_pix     (i_pix),
    .o_pix     (o_pix)
);

//--- verif/vid_proc_tb.sv
`timescale 1ns/1ps
`include "vid_defines.svh"

module vid_proc_tb;

    import vid_pkg::*;

    localparam int WR_CYCLES    = 48;
    localparam int FLUSH_CYCLES = 8;
    localparam int ACK_WAIT     = 16;
    localparam int PIX_CYCLES   = 66 + 64 + 48 + 40 + 16;
    localparam int TEST_CYCLES  = 10 + PIX_CYCLES + 10 * WR_CYCLES + 6 * FLUSH_CYCLES;

    logic          clk;
    logic          rstn;
    vid_rgb_t      i_pix;
    logic          i_cfg_req;
    logic          i_cfg_addr;
    vid_cfg_word_u i_cfg_data;
    logic          o_cfg_ack;
    vid_mono_t     o_pix;

    // Expected output per driven cycle with the oldest at the front
    vid_mono_t exp_q[$];
    bit        chk_y_q[$];

    // Shadow of the configuration registers
    int                    sh_offset;
    logic [`VID_PIX_W-1:0] sh_thresh;
    logic                  sh_bin_en;

    logic [15:0] lfsr;
    int          value_errs;
    int          ack_errs;

    vid_clk_gen vid_clk_gen_i (
        .o_clk  (clk),
        .o_rstn (rstn)
    );

    vid_proc_top vid_proc_top_i (
        .clk        (clk),
        .rstn       (rstn),
        .i_pix      (i_pix),
        .i_cfg_req  (i_cfg_req),
        .i_cfg_addr (i_cfg_addr),
        .i_cfg_data (i_cfg_data),
        .o_cfg_ack  (o_cfg_ack),
        .o_pix      (o_pix)
    );

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Galois LFSR stepped once per bit
    function automatic logic lfsr_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic logic [`VID_PIX_W-1:0] rand_bits(input int n);
        logic [`VID_PIX_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[`VID_PIX_W-2:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Active pixel with random low bits OR'd into each component base
    function automatic vid_rgb_t shade_pix(input logic [`VID_PIX_W-1:0] base, input int nbits);
        vid_rgb_t p;
        p    = '0;
        p.de = 1'b1;
        p.r  = base | rand_bits(nbits);
        p.g  = base | rand_bits(nbits);
        p.b  = base | rand_bits(nbits);
        return p;
    endfunction

    function automatic vid_cfg_word_u bright_word(input int off);
        vid_cfg_word_u w;
        w               = '0;
        w.bright.offset = off[`VID_OFF_W-1:0];
        return w;
    endfunction

    function automatic vid_cfg_word_u thresh_word(input logic en, input logic [7:0] th);
        vid_cfg_word_u w;
        w               = '0;
        w.thresh.en     = en;
        w.thresh.thresh = th;
        return w;
    endfunction

    // Weighted gray plus offset with clamp and the optional threshold
    function automatic logic [`VID_PIX_W-1:0] ref_y(input vid_rgb_t p);
        int w;
        int s;
        w = `VID_W_R * int'(p.r) + `VID_W_G * int'(p.g) + `VID_W_B * int'(p.b);
        s = w / 256 + sh_offset;
        if (s < 0) begin
            s = 0;
        end else if (s > 255) begin
            s = 255;
        end
        if (sh_bin_en) begin
            s = (s >= int'(sh_thresh)) ? 255 : 0;
        end
        return s[`VID_PIX_W-1:0];
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_mono(input vid_mono_t act, input vid_mono_t exp, input bit chk_y,
                              input string name);
        vid_mono_t a;
        vid_mono_t e;
        a = act;
        e = exp;
        // Gray value only meaningful while de is high
        if (!chk_y) begin
            a.y = '0;
            e.y = '0;
        end
        if (a !== e) begin
            value_errs++;
            $display("** Error %s: expected %h, got %h at %0t", name, e, a, $time);
        end
    endtask

    task automatic check_ack(input logic act, input logic exp, input string name);
        if (act !== exp) begin
            ack_errs++;
            $display("** Error %s: expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    // Check the output due this cycle and then drive the next input
    task automatic drive_pix(input vid_rgb_t p, input bit chk_y);
        vid_mono_t e;
        bit        c;
        @(negedge clk);
        if (exp_q.size() == 5) begin
            e = exp_q.pop_front();
            c = chk_y_q.pop_front();
            check_mono(o_pix, e, c, "o_pix");
        end
        i_pix   = p;
        e.vsync = p.vsync;
        e.hsync = p.hsync;
        e.de    = p.de;
        e.y     = ref_y(p);
        exp_q.push_back(e);
        chk_y_q.push_back(chk_y && p.de);
    endtask

    task automatic idle(input int n);
        repeat (n) drive_pix('0, 1'b0);
    endtask

    task automatic write_cfg(input logic addr, input vid_cfg_word_u w);
        int n;
        idle(6);
        check_ack(o_cfg_ack, 1'b0, "o_cfg_ack");
        i_cfg_addr = addr;
        i_cfg_data = w;
        idle(1);
        i_cfg_req = 1'b1;
        n = 0;
        while (o_cfg_ack !== 1'b1 && n < ACK_WAIT) begin
            idle(1);
            n++;
        end
        if (o_cfg_ack !== 1'b1) begin
            ack_errs++;
            $display("Config write to address %0d was never acknowledged", addr);
        end else begin
            repeat (3) begin
                idle(1);
                check_ack(o_cfg_ack, 1'b1, "o_cfg_ack");
            end
        end
        i_cfg_req = 1'b0;
        n = 0;
        while (o_cfg_ack !== 1'b0 && n < ACK_WAIT) begin
            idle(1);
            n++;
        end
        if (o_cfg_ack !== 1'b0) begin
            ack_errs++;
            $display("Config ack stayed high after the request was released");
        end
        if (addr) begin
            sh_thresh = w.thresh.thresh;
            sh_bin_en = w.thresh.en;
        end else begin
            sh_offset = int'($signed(w.bright.offset));
        end
        idle(6);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic reset_values();
        @(negedge clk);
        check_ack(o_cfg_ack, 1'b0, "o_cfg_ack");
        check_mono(o_pix, '0, 1'b0, "o_pix");
    endtask

    task automatic gray_conversion();
        repeat (64) drive_pix(shade_pix(8'h00, 8), 1'b1);
        drive_pix(shade_pix(8'hFF, 0), 1'b1);
        drive_pix(shade_pix(8'h00, 0), 1'b1);
        idle(FLUSH_CYCLES);
    endtask

    task automatic brightness_offset();
        write_cfg(1'b0, bright_word(100));
        repeat (16) drive_pix(shade_pix(8'hC0, 6), 1'b1);
        repeat (16) drive_pix(shade_pix(8'h70, 4), 1'b1);
        write_cfg(1'b0, bright_word(-100));
        repeat (16) drive_pix(shade_pix(8'h00, 6), 1'b1);
        repeat (16) drive_pix(shade_pix(8'h70, 4), 1'b1);
        write_cfg(1'b0, bright_word(`VID_BRIGHT_DEFAULT));
    endtask

    task automatic threshold_mode();
        write_cfg(1'b1, thresh_word(1'b1, 8'd100));
        repeat (32) drive_pix(shade_pix(8'h00, 8), 1'b1);
        write_cfg(1'b1, thresh_word(1'b0, 8'd100));
        repeat (16) drive_pix(shade_pix(8'h00, 8), 1'b1);
        write_cfg(1'b1, thresh_word(1'b0, `VID_THRESH_DEFAULT));
    endtask

    task automatic sync_alignment();
        vid_rgb_t p;
        for (int i = 0; i < 40; i++) begin
            p       = shade_pix(8'h00, 8);
            p.vsync = (i < 3);
            p.hsync = (i % 10 == 0);
            p.de    = (i % 10 >= 2) && (i % 10 < 8);
            drive_pix(p, 1'b1);
        end
        idle(FLUSH_CYCLES);
    endtask

    // Threshold word whose low bits would read as offset 200
    task automatic cfg_handshake();
        write_cfg(1'b0, bright_word(40));
        write_cfg(1'b1, thresh_word(1'b0, 8'hC8));
        repeat (16) drive_pix(shade_pix(8'h00, 8), 1'b1);
        write_cfg(1'b0, bright_word(`VID_BRIGHT_DEFAULT));
        write_cfg(1'b1, thresh_word(1'b0, `VID_THRESH_DEFAULT));
    endtask

    initial begin
        i_pix      = '0;
        i_cfg_req  = 1'b0;
        i_cfg_addr = 1'b0;
        i_cfg_data = '0;
        lfsr       = 16'd97;
        sh_offset  = `VID_BRIGHT_DEFAULT;
        sh_thresh  = `VID_THRESH_DEFAULT;
        sh_bin_en  = 1'b0;
        value_errs = 0;
        ack_errs   = 0;
        @(posedge rstn);
        reset_values();
        gray_conversion();
        brightness_offset();
        threshold_mode();
        sync_alignment();
        cfg_handshake();
        idle(FLUSH_CYCLES);
        $display("Errors: value %0d, handshake %0d, assertion %0d", value_errs, ack_errs,
                 vid_proc_top_i.vid_proc_sva_i.sva_errs);
        if (value_errs + ack_errs + vid_proc_top_i.vid_proc_sva_i.sva_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog at twice the expected run length
    initial begin
        #(TEST_CYCLES * 2 * 10);
        $display("Watchdog expired after %0d cycles, the run did not complete", TEST_CYCLES * 2);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+logic
logic/vid_pkg.sv
logic/vid_cfg_regs.sv
logic/vid_gray_conv.sv
logic/vid_binarize.sv
logic/vid_proc_top.sv
verif/vid_clk_gen.sv
verif/vid_proc_sva.sv
verif/vid_proc_tb.sv
